//--- logic/uno_pkg.sv
package uno_pkg;

    localparam int NUM_SEATS = 4;
    localparam int COUNT_W   = 7;

    localparam logic [COUNT_W-1:0] DEAL_SIZE = 7'd7;
    localparam logic [COUNT_W-1:0] MAX_HAND  = 7'd108; // whole deck

    localparam logic [2:0] PENALTY_DRAW_TWO  = 3'd2;
    localparam logic [2:0] PENALTY_DRAW_FOUR = 3'd4;

    // number cards 0..9, action cards 10..14
    typedef enum logic [3:0] {
        CV_ZERO, CV_ONE, CV_TWO, CV_THREE, CV_FOUR,
        CV_FIVE, CV_SIX, CV_SEVEN, CV_EIGHT, CV_NINE,
        CV_SKIP, CV_REVERSE, CV_DRAW_TWO, CV_WILD, CV_WILD_DRAW_FOUR
    } card_value_e;

    typedef struct packed {
        logic [1:0]  colour;
        card_value_e value;
    } card_t;

    typedef enum logic {
        ACT_DRAW,
        ACT_PLAY
    } action_kind_e;

    typedef struct packed {
        action_kind_e kind;
        card_t        card;
    } seat_action_t;

    typedef logic [1:0] seat_t;

    typedef logic [NUM_SEATS-1:0][COUNT_W-1:0] hand_counts_t;

    typedef struct packed {
        seat_t      next_seat;
        logic       reversed;       // 1: seat number decreases
        seat_t      penalty_seat;
        logic [2:0] penalty_amount; // 0, 2 or 4
    } turn_result_t;

    typedef struct packed {
        logic [COUNT_W-1:0] count;
        logic               emptied;
    } count_result_t;

    typedef enum logic [2:0] {
        RS_IDLE,
        RS_WAIT,
        RS_RESOLVE,
        RS_COMMIT,
        RS_ACK,
        RS_END
    } ref_state_e;

endpackage

//--- logic/turn_order.sv
`timescale 1ns/1ps

module turn_order (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_resolve,
    input  uno_pkg::seat_action_t i_action,
    input  uno_pkg::seat_t        i_seat,
    input  logic                  i_reversed,
    output uno_pkg::turn_result_t o_result
);
    import uno_pkg::*;

    seat_t        step;     // +1 forward, -1 (3) reversed
    seat_t        victim;   // seat right after the actor
    seat_t        jump;     // seat two steps on
    turn_result_t result_w, result_r;

    assign step   = i_reversed ? 2'd3 : 2'd1;
    assign victim = i_seat + step;
    assign jump   = victim + step;

    assign o_result = result_r;

    always_comb begin
        result_w.next_seat      = victim;
        result_w.reversed       = i_reversed;
        result_w.penalty_seat   = victim;
        result_w.penalty_amount = 3'd0;
        if (i_action.kind == ACT_PLAY) begin
            case (i_action.card.value)
                CV_SKIP: begin
                    result_w.next_seat = jump;
                end
                CV_REVERSE: begin // flip first, then one step the new way
                    result_w.reversed  = ~i_reversed;
                    result_w.next_seat = i_seat - step;
                end
                CV_DRAW_TWO: begin
                    result_w.next_seat      = jump;
                    result_w.penalty_amount = PENALTY_DRAW_TWO;
                end
                CV_WILD_DRAW_FOUR: begin
                    result_w.next_seat      = jump;
                    result_w.penalty_amount = PENALTY_DRAW_FOUR;
                end
                default: begin
                    result_w.next_seat = victim; // numbers and plain wild
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_resolve) begin
            result_r <= result_w;
        end
    end

    // a draw never hands out a penalty to the next seat
    a_draw_no_penalty: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_resolve && i_action.kind == ACT_DRAW) |=> (o_result.penalty_amount == 3'd0)
    ) else $error("penalty issued for a draw action");

endmodule

//--- logic/hand_counter.sv
`timescale 1ns/1ps

module hand_counter (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_deal,
    input  logic                   i_resolve,
    input  uno_pkg::seat_action_t  i_action,
    input  uno_pkg::seat_t         i_seat,
    input  logic                   i_commit,
    input  uno_pkg::seat_t         i_penalty_seat,
    input  logic [2:0]             i_penalty_amount,
    output uno_pkg::count_result_t o_result,
    output uno_pkg::hand_counts_t  o_counts
);
    import uno_pkg::*;

    hand_counts_t       counts_w, counts_r;
    count_result_t      result_w, result_r;
    logic [COUNT_W-1:0] actor_count;
    logic [COUNT_W-1:0] penalty_ext;

    assign actor_count = counts_r[i_seat];
    assign penalty_ext = {{(COUNT_W-3){1'b0}}, i_penalty_amount};

    assign o_result = result_r;
    assign o_counts = counts_r;

    // proposal for the actor only, committed later
    always_comb begin
        if (i_action.kind == ACT_PLAY) begin
            result_w.count   = actor_count - 1'b1;
            result_w.emptied = (actor_count == 7'd1);
        end
        else begin
            result_w.count   = actor_count + 1'b1;
            result_w.emptied = 1'b0;
        end
    end

    always_comb begin
        counts_w = counts_r;
        if (i_deal) begin
            for (int k = 0; k < NUM_SEATS; k++) begin
                counts_w[k] = DEAL_SIZE;
            end
        end
        else if (i_commit) begin
            counts_w[i_seat]         = result_r.count;
            // victim is always a different seat from the actor
            counts_w[i_penalty_seat] = counts_r[i_penalty_seat] + penalty_ext;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            counts_r <= '0;
        end
        else begin
            counts_r <= counts_w;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_resolve) begin
            result_r <= result_w;
        end
    end

    for (genvar k = 0; k < NUM_SEATS; k++) begin : g_bound
        a_count_max: assert property (
            @(posedge i_clk) disable iff (!i_rst_n)
            counts_r[k] <= MAX_HAND
        ) else $error("hand count of seat %0d above deck size", k);
    end

    // the game must have ended before an empty hand gets a turn
    a_no_play_from_empty: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_resolve && i_action.kind == ACT_PLAY) |-> (actor_count != '0)
    ) else $error("play resolved for an empty hand");

endmodule

//--- logic/referee_fsm.sv
`timescale 1ns/1ps

module referee_fsm (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic                  i_req,
    input  uno_pkg::seat_action_t i_action,
    input  uno_pkg::turn_result_t i_turn,
    input  uno_pkg::count_result_t i_count,
    output logic                  o_ack,
    output logic                  o_end,
    output uno_pkg::card_t        o_last_card,
    output uno_pkg::seat_action_t o_action,
    output uno_pkg::seat_t        o_seat,
    output logic                  o_reversed,
    output logic                  o_deal,
    output logic                  o_resolve,
    output logic                  o_commit,
    output uno_pkg::seat_t        o_penalty_seat,
    output logic [2:0]            o_penalty_amount
);
    import uno_pkg::*;

    ref_state_e   state_w, state_r;
    seat_t        seat_w, seat_r;
    logic         reversed_w, reversed_r;
    card_t        last_card_w, last_card_r;
    logic         ack_w, ack_r;
    seat_action_t action_r;

    assign o_deal    = (state_r == RS_IDLE) && i_start;
    assign o_resolve = (state_r == RS_RESOLVE);
    assign o_commit  = (state_r == RS_COMMIT);
    assign o_end     = (state_r == RS_END);

    assign o_ack       = ack_r;
    assign o_last_card = last_card_r;
    assign o_action    = action_r;
    assign o_seat      = seat_r;
    assign o_reversed  = reversed_r;

    // a winning play carries no penalty
    assign o_penalty_seat   = i_turn.penalty_seat;
    assign o_penalty_amount = i_count.emptied ? 3'd0 : i_turn.penalty_amount;

    always_comb begin
        state_w     = state_r;
        seat_w      = seat_r;
        reversed_w  = reversed_r;
        last_card_w = last_card_r;
        ack_w       = ack_r & i_req; // drop once req is seen low
        case (state_r)
            RS_IDLE: begin
                if (i_start) begin
                    state_w     = RS_WAIT;
                    seat_w      = '0;
                    reversed_w  = 1'b0;
                    last_card_w = '0;
                end
            end
            RS_WAIT: begin
                if (i_req) begin
                    state_w = RS_RESOLVE;
                end
            end
            RS_RESOLVE: begin
                state_w = RS_COMMIT; // side units register results here
            end
            RS_COMMIT: begin
                ack_w = 1'b1;
                if (action_r.kind == ACT_PLAY) begin
                    last_card_w = action_r.card;
                end
                if (i_count.emptied) begin
                    state_w = RS_END; // seat and direction stay put
                end
                else begin
                    state_w    = RS_ACK;
                    seat_w     = i_turn.next_seat;
                    reversed_w = i_turn.reversed;
                end
            end
            RS_ACK: begin
                if (!i_req) begin
                    state_w = RS_WAIT;
                end
            end
            RS_END: begin
                if (!i_start) begin
                    state_w = RS_IDLE;
                end
            end
            default: begin
                state_w = RS_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r     <= RS_IDLE;
            seat_r      <= '0;
            reversed_r  <= 1'b0;
            last_card_r <= '0;
            ack_r       <= 1'b0;
        end
        else begin
            state_r     <= state_w;
            seat_r      <= seat_w;
            reversed_r  <= reversed_w;
            last_card_r <= last_card_w;
            ack_r       <= ack_w;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == RS_WAIT && i_req) begin
            action_r <= i_action;
        end
    end

    a_ack_after_req_low: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $fell(o_ack) |-> !$past(i_req)
    ) else $error("ack dropped while req still high");

    a_resolve_from_req: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_resolve |-> $past(state_r == RS_WAIT && i_req)
    ) else $error("resolve without an accepted request");

endmodule

//--- logic/uno_referee.sv
`timescale 1ns/1ps

module uno_referee (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic                  i_req,
    input  uno_pkg::seat_action_t i_action,
    output logic                  o_ack,
    output logic                  o_end,
    output uno_pkg::seat_t        o_seat,
    output uno_pkg::hand_counts_t o_hand_num,
    output uno_pkg::card_t        o_last_card
);
    import uno_pkg::*;

    seat_action_t  action;       // registered action under resolve
    logic          reversed;
    logic          deal;
    logic          resolve;
    logic          commit;
    seat_t         penalty_seat;
    logic [2:0]    penalty_amount;
    turn_result_t  turn;
    count_result_t count;

    referee_fsm referee_fsm_i (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_start          (i_start),
        .i_req            (i_req),
        .i_action         (i_action),
        .i_turn           (turn),
        .i_count          (count),
        .o_ack            (o_ack),
        .o_end            (o_end),
        .o_last_card      (o_last_card),
        .o_action         (action),
        .o_seat           (o_seat),
        .o_reversed       (reversed),
        .o_deal           (deal),
        .o_resolve        (resolve),
        .o_commit         (commit),
        .o_penalty_seat   (penalty_seat),
        .o_penalty_amount (penalty_amount)
    );

    turn_order turn_order_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_resolve  (resolve),
        .i_action   (action),
        .i_seat     (o_seat),
        .i_reversed (reversed),
        .o_result   (turn)
    );

    hand_counter hand_counter_i (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_deal           (deal),
        .i_resolve        (resolve),
        .i_action         (action),
        .i_seat           (o_seat),
        .i_commit         (commit),
        .i_penalty_seat   (penalty_seat),
        .i_penalty_amount (penalty_amount),
        .o_result         (count),
        .o_counts         (o_hand_num)
    );

endmodule

//--- testbench/uno_referee_tb.sv
`timescale 1ns/1ps

module uno_referee_tb;
    import uno_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int N_DIRECTED      = 10;
    localparam int N_RANDOM        = 200;
    localparam int N_ACTIONS       = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_CYCLES = N_ACTIONS * 10 + 200;

    logic         i_clk = 1'b0;
    logic         i_rst_n;
    logic         i_start;
    logic         i_req;
    seat_action_t i_action;
    logic         o_ack;
    logic         o_end;
    seat_t        o_seat;
    hand_counts_t o_hand_num;
    card_t        o_last_card;

    // reference model state
    hand_counts_t exp_counts;
    seat_t        exp_seat;
    logic         exp_rev;
    card_t        exp_last;
    logic         exp_end;

    int errors = 0;
    int seed   = 4635;

    uno_referee uno_referee_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_req       (i_req),
        .i_action    (i_action),
        .o_ack       (o_ack),
        .o_end       (o_end),
        .o_seat      (o_seat),
        .o_hand_num  (o_hand_num),
        .o_last_card (o_last_card)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic note_failure(input string what);
        errors++;
        $display("** Error at %0t: %s", $time, what);
    endtask

    function automatic seat_action_t make_action(input action_kind_e kind,
                                                 input card_value_e value,
                                                 input logic [1:0] colour);
        seat_action_t act;
        act.kind        = kind;
        act.card.colour = colour;
        act.card.value  = value;
        return act;
    endfunction

    task automatic restart_model();
        for (int k = 0; k < NUM_SEATS; k++) begin
            exp_counts[k] = 7'd7;
        end
        exp_seat = 2'd0;
        exp_rev  = 1'b0;
        exp_last = '0;
        exp_end  = 1'b0;
    endtask

    // turn rules applied to the model for the seat on turn
    task automatic apply_rules(input seat_action_t act);
        seat_t actor;
        seat_t step;
        seat_t victim;
        actor  = exp_seat;
        step   = exp_rev ? 2'd3 : 2'd1; // -1 mod 4 when reversed
        victim = actor + step;
        if (act.kind == ACT_DRAW) begin
            exp_counts[actor] = exp_counts[actor] + 7'd1;
            exp_seat          = victim;
        end
        else begin
            exp_last          = act.card;
            exp_counts[actor] = exp_counts[actor] - 7'd1;
            if (exp_counts[actor] == 7'd0) begin
                exp_end = 1'b1; // winner keeps the seat
            end
            else begin
                case (act.card.value)
                    CV_SKIP: exp_seat = victim + step;
                    CV_REVERSE: begin
                        exp_rev  = ~exp_rev;
                        exp_seat = actor - step;
                    end
                    CV_DRAW_TWO: begin
                        exp_counts[victim] = exp_counts[victim] + 7'd2;
                        exp_seat           = victim + step;
                    end
                    CV_WILD_DRAW_FOUR: begin
                        exp_counts[victim] = exp_counts[victim] + 7'd4;
                        exp_seat           = victim + step;
                    end
                    default: exp_seat = victim;
                endcase
            end
        end
    endtask

    // one four-phase exchange, req held for extra cycles after ack
    task automatic do_action(input seat_action_t act, input int hold);
        @(negedge i_clk);
        apply_rules(act);
        i_action = act;
        i_req    = 1'b1;
        @(negedge i_clk);
        while (!o_ack) @(negedge i_clk);
        repeat (hold) @(negedge i_clk);
        i_req = 1'b0;
        @(negedge i_clk);
        while (o_ack) @(negedge i_clk);
    endtask

    task automatic redeal();
        repeat (3) @(negedge i_clk); // end flag must survive start high
        i_start = 1'b0;
        @(negedge i_clk);
        while (o_end) @(negedge i_clk);
        @(negedge i_clk);
        i_start = 1'b1;
        restart_model();
        @(negedge i_clk);
    endtask

    a_deal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_start) |=> (o_hand_num == {NUM_SEATS{DEAL_SIZE}} && o_seat == 2'd0
                            && !o_end && !o_ack)
    ) else note_failure("deal did not load seven cards per seat at seat 0");

    a_ack_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ($past(i_req, 3) && !$past(i_req, 4)) |-> $rose(o_ack)
    ) else note_failure("ack missing two edges after req was sampled");

    a_ack_not_early: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_ack) |-> ($past(i_req, 3) && !$past(i_req, 4))
    ) else note_failure("ack rose at the wrong edge");

    a_model_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_ack |-> (o_hand_num == exp_counts && o_seat == exp_seat
                   && o_last_card == exp_last && o_end == exp_end)
    ) else note_failure("outputs differ from the model at ack");

    a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_ack && $past(o_ack)) |-> ($stable(o_hand_num) && $stable(o_seat)
                                     && $stable(o_last_card))
    ) else note_failure("outputs moved while ack was held");

    a_ack_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_ack && i_req) |=> o_ack
    ) else note_failure("ack dropped with req still high");

    a_ack_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_req) |=> !o_ack
    ) else note_failure("ack still high one edge after req fell");

    a_end_with_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_end) |-> $rose(o_ack)
    ) else note_failure("end flag rose without ack");

    a_end_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_end && i_start) |=> o_end
    ) else note_failure("end flag fell while start was high");

    a_end_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_end && !i_start) |=> !o_end
    ) else note_failure("end flag stayed high after start fell");

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the action sequence completed");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0]  rnd;
        seat_action_t act;
        int           hold;
        i_rst_n  = 1'b0;
        i_start  = 1'b0;
        i_req    = 1'b0;
        i_action = '0;
        restart_model();
        repeat (4) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);

        do_action(make_action(ACT_PLAY, CV_SKIP, 2'd0), 0);           // 0 to 2
        do_action(make_action(ACT_PLAY, CV_REVERSE, 2'd1), 0);        // 2 to 1
        do_action(make_action(ACT_PLAY, CV_DRAW_TWO, 2'd2), 0);       // seat 0 takes 2
        do_action(make_action(ACT_PLAY, CV_WILD_DRAW_FOUR, 2'd3), 0); // seat 2 takes 4
        do_action(make_action(ACT_PLAY, CV_SKIP, 2'd0), 0);
        do_action(make_action(ACT_PLAY, CV_REVERSE, 2'd1), 0);        // forward again
        do_action(make_action(ACT_PLAY, CV_DRAW_TWO, 2'd2), 0);
        do_action(make_action(ACT_DRAW, CV_ZERO, 2'd0), 0);
        do_action(make_action(ACT_PLAY, CV_WILD_DRAW_FOUR, 2'd3), 2);
        do_action(make_action(ACT_PLAY, CV_SEVEN, 2'd1), 5);          // back pressure

        // mostly plays so games keep ending
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $random(seed);
            act = make_action((rnd[3:0] < 4'd2) ? ACT_DRAW : ACT_PLAY,
                              card_value_e'(4'(rnd[31:8] % 15)), rnd[5:4]);
            hold = (rnd[7:6] == 2'b11) ? 3 : 0;
            do_action(act, hold);
            if (exp_end) begin
                redeal();
            end
        end

        repeat (5) @(negedge i_clk);
        $display("checks finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- src.f
logic/uno_pkg.sv
logic/turn_order.sv
logic/hand_counter.sv
logic/referee_fsm.sv
logic/uno_referee.sv
testbench/uno_referee_tb.sv

//--- Makefile
SIM = obj_dir/Vuno_referee_tb
SOURCES = $(shell cat src.f)

.PHONY: all run lint clean

all: run

$(SIM): src.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module uno_referee_tb -f src.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "Test passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module uno_referee \
		logic/uno_pkg.sv logic/turn_order.sv logic/hand_counter.sv \
		logic/referee_fsm.sv logic/uno_referee.sv

clean:
	rm -rf obj_dir sim.log
